// File: filelist.f
hw/accelerator_arithmetic_pkg.sv
hw/scalar_float_adder.sv
hw/scalar_float_multiplier.sv
hw/scalar_float_divider.sv
hw/scalar_float_unit.sv
bench/scalar_float_unit_asserts.sv
bench/scalar_float_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the scalar float unit regression with Verilator

verilator --binary --timing --assert -Wno-fatal \
  --top-module scalar_float_unit_tb -f filelist.f \
  -o scalar_float_unit_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/scalar_float_unit_sim > sim.log 2>&1

grep -qx "Regression passed" sim.log && exit 0 || { cat sim.log; exit 1; }

// File: bench/scalar_float_unit_tb.sv
// Directed testbench for the scalar floating-point unit
// Each test task pulses start, waits for the ready pulse and checks data_out and overflow
// Expected values come from real arithmetic and the package overflow rule

`timescale 1ns/100ps

module scalar_float_unit_tb;

  typedef logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0]      data_t;
  typedef logic [accelerator_arithmetic_pkg::OPERATION_SIZE-1:0] op_t;

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  localparam int          CLOCK_PERIOD = 8;
  localparam int          RESET_CYCLES = 10;
  localparam int          READY_WAIT   = 4;
  localparam int unsigned RANDOM_SEED  = 32'h826950b6;
  // About 55 operations of 3 to 4 cycles plus reset, far below this
  localparam int          CYCLE_LIMIT  = 3000;

  // Double-precision bit patterns
  localparam data_t VALUE_ONE      = 64'h3FF0_0000_0000_0000;
  localparam data_t VALUE_TWO      = 64'h4000_0000_0000_0000;
  localparam data_t VALUE_THREE    = 64'h4008_0000_0000_0000;
  localparam data_t VALUE_FOUR     = 64'h4010_0000_0000_0000;
  localparam data_t VALUE_SIX      = 64'h4018_0000_0000_0000;
  localparam data_t VALUE_HALF     = 64'h3FE0_0000_0000_0000;
  localparam data_t VALUE_1P5      = 64'h3FF8_0000_0000_0000;
  localparam data_t VALUE_2P5      = 64'h4004_0000_0000_0000;
  localparam data_t VALUE_NEG_2P5  = 64'hC004_0000_0000_0000;
  localparam data_t VALUE_NEG_0P75 = 64'hBFE8_0000_0000_0000;
  localparam data_t NEGATIVE_ZERO  = 64'h8000_0000_0000_0000;
  localparam data_t LARGEST_FINITE = 64'h7FEF_FFFF_FFFF_FFFF;
  localparam data_t POSITIVE_INF   = 64'h7FF0_0000_0000_0000;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic  CLK = 1'b0;
  logic  RST;
  logic  start;
  op_t   operation;
  data_t data_a;
  data_t data_b;
  logic  ready;
  data_t data_out;
  logic  overflow;

  int data_errors  = 0;
  int flag_errors  = 0;
  int other_errors = 0;
  int cycle_count  = 0;

  // Result of the latest checked operation
  data_t last_data;
  logic  last_flag;

  //////////////////////////////////////////////////////////////////////
  // DUT, clock and timeout
  //////////////////////////////////////////////////////////////////////

  scalar_float_unit scalar_float_unit_inst (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .operation (operation),
    .ready     (ready),
    .data_a    (data_a),
    .data_b    (data_b),
    .data_out  (data_out),
    .overflow  (overflow)
  );

  always #(CLOCK_PERIOD / 2) CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles", CYCLE_LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////////////////////////////////////////////

  function automatic data_t reference_result(input op_t op, input data_t a, input data_t b);
    real ra;
    real rb;
    real rr;
    ra = $bitstoreal(a);
    rb = $bitstoreal(b);
    case (op)
      accelerator_arithmetic_pkg::OP_ADD: rr = ra + rb;
      accelerator_arithmetic_pkg::OP_SUB: rr = ra - rb;
      accelerator_arithmetic_pkg::OP_MUL: rr = ra * rb;
      default:                            rr = ra / rb;
    endcase
    return $realtobits(rr);
  endfunction

  // Division by a zero magnitude always raises the flag
  function automatic logic reference_overflow(input op_t op, input data_t a, input data_t b,
                                              input data_t result);
    logic zero_divide;
    zero_divide = (op == accelerator_arithmetic_pkg::OP_DIV) && (b[62:0] == 63'd0);
    return zero_divide | accelerator_arithmetic_pkg::float_overflow(a, b, result);
  endfunction

  task automatic check_data(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
      data_errors++;
      $display("error: %s = %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      flag_errors++;
      $display("error: %s = %h, expected %h", name, actual, expected);
    end
  endtask

  // Random double, exponent within 2^-20 to 2^20
  function automatic data_t random_double();
    logic [63:0] raw;
    logic [31:0] exponent_raw;
    int          exponent_value;
    raw            = {$urandom, $urandom};
    exponent_raw   = $urandom_range(40, 0);
    exponent_value = 1003 + int'(exponent_raw);
    return {raw[63], exponent_value[10:0], raw[51:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Drive and wait
  //////////////////////////////////////////////////////////////////////

  // Start is high for one sampling edge
  task automatic launch(input op_t op, input data_t a, input data_t b);
    @(posedge CLK);
    start     <= 1'b1;
    operation <= op;
    data_a    <= a;
    data_b    <= b;
    @(posedge CLK);
    start <= 1'b0;
  endtask

  // Outputs sampled on the falling edge
  task automatic wait_ready(output logic seen);
    int k;
    seen = 1'b0;
    for (k = 0; k < READY_WAIT && !seen; k++) begin
      @(negedge CLK);
      seen = ready;
    end
    if (!seen) begin
      other_errors++;
      $display("no ready pulse after start");
    end
  endtask

  task automatic check_result(input op_t op, input data_t a, input data_t b);
    data_t expected_data;
    logic  expected_flag;
    expected_data = reference_result(op, a, b);
    expected_flag = reference_overflow(op, a, b, expected_data);
    check_data("data_out", data_out, expected_data);
    check_flag("overflow", overflow, expected_flag);
    last_data = data_out;
    last_flag = overflow;
  endtask

  task automatic run_operation(input op_t op, input data_t a, input data_t b);
    logic seen;
    launch(op, a, b);
    wait_ready(seen);
    if (seen) begin
      check_result(op, a, b);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    @(negedge CLK);
    check_flag("ready", ready, 1'b0);
    check_flag("overflow", overflow, 1'b0);
    check_data("data_out", data_out, accelerator_arithmetic_pkg::ZERO_DATA);
  endtask

  task automatic test_add_sub();
    int i;
    run_operation(accelerator_arithmetic_pkg::OP_ADD, VALUE_1P5, VALUE_TWO);
    run_operation(accelerator_arithmetic_pkg::OP_SUB, VALUE_ONE, VALUE_FOUR);
    // Cancellation to zero
    run_operation(accelerator_arithmetic_pkg::OP_ADD, VALUE_2P5, VALUE_NEG_2P5);
    check_data("data_out", last_data, accelerator_arithmetic_pkg::ZERO_DATA);
    run_operation(accelerator_arithmetic_pkg::OP_SUB, VALUE_THREE, VALUE_THREE);
    check_data("data_out", last_data, accelerator_arithmetic_pkg::ZERO_DATA);
    for (i = 0; i < 10; i++) begin
      if (i % 2 == 0) begin
        run_operation(accelerator_arithmetic_pkg::OP_ADD, random_double(), random_double());
      end else begin
        run_operation(accelerator_arithmetic_pkg::OP_SUB, random_double(), random_double());
      end
      check_flag("overflow", last_flag, 1'b0);
    end
  endtask

  task automatic test_multiply();
    int i;
    run_operation(accelerator_arithmetic_pkg::OP_MUL, VALUE_1P5, VALUE_TWO);
    run_operation(accelerator_arithmetic_pkg::OP_MUL, VALUE_NEG_0P75, VALUE_FOUR);
    run_operation(accelerator_arithmetic_pkg::OP_MUL, VALUE_HALF, VALUE_HALF);
    for (i = 0; i < 10; i++) begin
      run_operation(accelerator_arithmetic_pkg::OP_MUL, random_double(), random_double());
    end
    // Products past the finite range
    run_operation(accelerator_arithmetic_pkg::OP_MUL, LARGEST_FINITE, LARGEST_FINITE);
    check_data("data_out", last_data, POSITIVE_INF);
    check_flag("overflow", last_flag, 1'b1);
    run_operation(accelerator_arithmetic_pkg::OP_MUL, LARGEST_FINITE, VALUE_TWO);
    check_data("data_out", last_data, POSITIVE_INF);
    check_flag("overflow", last_flag, 1'b1);
  endtask

  task automatic test_divide();
    int i;
    run_operation(accelerator_arithmetic_pkg::OP_DIV, VALUE_SIX, VALUE_TWO);
    run_operation(accelerator_arithmetic_pkg::OP_DIV, VALUE_ONE, VALUE_FOUR);
    run_operation(accelerator_arithmetic_pkg::OP_DIV, VALUE_NEG_2P5, VALUE_HALF);
    for (i = 0; i < 10; i++) begin
      run_operation(accelerator_arithmetic_pkg::OP_DIV, random_double(), random_double());
    end
    // Zero divisors of both signs
    run_operation(accelerator_arithmetic_pkg::OP_DIV, VALUE_ONE,
                  accelerator_arithmetic_pkg::ZERO_DATA);
    check_data("data_out", last_data, POSITIVE_INF);
    check_flag("overflow", last_flag, 1'b1);
    run_operation(accelerator_arithmetic_pkg::OP_DIV, VALUE_NEG_2P5, NEGATIVE_ZERO);
    check_data("data_out", last_data, POSITIVE_INF);
    check_flag("overflow", last_flag, 1'b1);
  endtask

  // Starts two cycles apart, the next start goes out on the edge that raises ready
  task automatic test_mixed_sequence();
    op_t   ops [0:3];
    op_t   op_prev;
    data_t a_prev;
    data_t b_prev;
    data_t a_next;
    data_t b_next;
    int    i;
    ops[0] = accelerator_arithmetic_pkg::OP_ADD;
    ops[1] = accelerator_arithmetic_pkg::OP_MUL;
    ops[2] = accelerator_arithmetic_pkg::OP_SUB;
    ops[3] = accelerator_arithmetic_pkg::OP_DIV;
    op_prev = ops[0];
    a_prev  = random_double();
    b_prev  = random_double();
    launch(op_prev, a_prev, b_prev);
    for (i = 1; i <= 8; i++) begin
      a_next = random_double();
      b_next = random_double();
      @(posedge CLK);
      if (i < 8) begin
        start     <= 1'b1;
        operation <= ops[i % 4];
        data_a    <= a_next;
        data_b    <= b_next;
      end
      @(negedge CLK);
      if (!ready) begin
        other_errors++;
        $display("no ready pulse after start");
      end else begin
        check_result(op_prev, a_prev, b_prev);
      end
      op_prev = ops[i % 4];
      a_prev  = a_next;
      b_prev  = b_next;
      @(posedge CLK);
      start <= 1'b0;
    end
  endtask

  // Inputs move without start, the result must not
  task automatic test_held_result();
    data_t       held_data;
    logic        held_flag;
    logic [31:0] raw;
    int          i;
    run_operation(accelerator_arithmetic_pkg::OP_DIV, VALUE_ONE,
                  accelerator_arithmetic_pkg::ZERO_DATA);
    held_data = data_out;
    held_flag = overflow;
    for (i = 0; i < 6; i++) begin
      raw = $urandom;
      @(posedge CLK);
      operation <= raw[1:0];
      data_a    <= random_double();
      data_b    <= random_double();
      @(negedge CLK);
      check_flag("ready", ready, 1'b0);
      check_data("data_out", data_out, held_data);
      check_flag("overflow", overflow, held_flag);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(RANDOM_SEED));
    RST        = 1'b1;
    start      = 1'b0;
    operation  = accelerator_arithmetic_pkg::OP_ADD;
    data_a     = accelerator_arithmetic_pkg::ZERO_DATA;
    data_b     = accelerator_arithmetic_pkg::ZERO_DATA;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;

    test_reset_state();
    test_add_sub();
    test_multiply();
    test_divide();
    test_mixed_sequence();
    test_held_result();

    repeat (2) @(posedge CLK);
    $display("data_out errors %0d, flag errors %0d, other errors %0d",
             data_errors, flag_errors, other_errors);
    if (data_errors + flag_errors + other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: bench/scalar_float_unit_asserts.sv
// Start and ready timing checks for the scalar floating-point unit
// Bound into every scalar_float_unit instance

`timescale 1ns/100ps

module scalar_float_unit_asserts (
  input logic CLK,
  input logic RST,
  input logic start,
  input logic accept,
  input logic pending,
  input logic ready
);

  //////////////////////////////////////////////////////////////////////
  // Ready pulse
  //////////////////////////////////////////////////////////////////////

  // Single-cycle pulse
  ready_single_pulse: assert property (@(posedge CLK) disable iff (RST) ready |=> !ready)
    else $error("ready high in two consecutive cycles");

  // Ready high one clock after the edge that took start
  ready_after_accept: assert property (@(posedge CLK) disable iff (RST)
                                       accept |=> !ready ##1 ready)
    else $error("ready did not follow an accepted start");

  ready_has_start: assert property (@(posedge CLK) disable iff (RST)
                                    ready |-> $past(accept, 2))
    else $error("ready without an accepted start");

  //////////////////////////////////////////////////////////////////////
  // Start
  //////////////////////////////////////////////////////////////////////

  start_when_idle: assert property (@(posedge CLK) disable iff (RST) pending |-> !start)
    else $error("start raised while a result is pending");

endmodule

bind scalar_float_unit scalar_float_unit_asserts asserts_inst (
  .CLK     (CLK),
  .RST     (RST),
  .start   (start),
  .accept  (accept),
  .pending (pending),
  .ready   (ready)
);

// File: hw/scalar_float_unit.sv
// Top level of the scalar floating-point unit
// Routes each start to the adder, multiplier or divider by operation code
// and returns the result and overflow flag of the block that was started

`timescale 1ns/100ps

module scalar_float_unit (
  // Global
  input  logic                                              CLK,
  input  logic                                              RST,

  // Control
  input  logic                                              start,
  input  logic [accelerator_arithmetic_pkg::OPERATION_SIZE-1:0] operation,
  output logic                                              ready,

  // Data
  input  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0]      data_a,
  input  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0]      data_b,
  output logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0]      data_out,
  output logic                                              overflow
);

  //////////////////////////////////////////////////////////////////////
  // Block select codes
  //////////////////////////////////////////////////////////////////////

  localparam logic [1:0] SELECT_ADDER      = 2'd0;
  localparam logic [1:0] SELECT_MULTIPLIER = 2'd1;
  localparam logic [1:0] SELECT_DIVIDER    = 2'd2;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Start handling
  logic       accept;
  logic       pending;
  logic [1:0] operation_select;
  logic [1:0] block_select;

  // Per-block starts
  logic start_adder;
  logic start_multiplier;
  logic start_divider;

  // Per-block results
  logic                                         ready_adder;
  logic                                         ready_multiplier;
  logic                                         ready_divider;
  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] data_adder;
  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] data_multiplier;
  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] data_divider;
  logic                                         overflow_adder;
  logic                                         overflow_multiplier;
  logic                                         overflow_divider;

  //////////////////////////////////////////////////////////////////////
  // Start decode
  //////////////////////////////////////////////////////////////////////

  // Pending covers the cycle between start and ready
  assign accept = start & ~pending;

  always_comb begin
    case (operation)
      accelerator_arithmetic_pkg::OP_MUL: operation_select = SELECT_MULTIPLIER;
      accelerator_arithmetic_pkg::OP_DIV: operation_select = SELECT_DIVIDER;
      // Add and subtract share the adder
      default:                            operation_select = SELECT_ADDER;
    endcase
  end

  assign start_adder      = accept & (operation_select == SELECT_ADDER);
  assign start_multiplier = accept & (operation_select == SELECT_MULTIPLIER);
  assign start_divider    = accept & (operation_select == SELECT_DIVIDER);

  // Busy block, held until the next accepted start
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pending      <= 1'b0;
      block_select <= SELECT_ADDER;
    end else begin
      pending <= accept;
      if (accept) begin
        block_select <= operation_select;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////////////

  scalar_float_adder adder_inst (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start_adder),
    .subtract (operation[0]),
    .ready    (ready_adder),
    .data_a   (data_a),
    .data_b   (data_b),
    .data_out (data_adder),
    .overflow (overflow_adder)
  );

  scalar_float_multiplier multiplier_inst (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start_multiplier),
    .ready    (ready_multiplier),
    .data_a   (data_a),
    .data_b   (data_b),
    .data_out (data_multiplier),
    .overflow (overflow_multiplier)
  );

  scalar_float_divider divider_inst (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start_divider),
    .ready    (ready_divider),
    .data_a   (data_a),
    .data_b   (data_b),
    .data_out (data_divider),
    .overflow (overflow_divider)
  );

  //////////////////////////////////////////////////////////////////////
  // Output select
  //////////////////////////////////////////////////////////////////////

  // Only one block can pulse at a time
  assign ready = ready_adder | ready_multiplier | ready_divider;

  always_comb begin
    case (block_select)
      SELECT_MULTIPLIER: begin
        data_out = data_multiplier;
        overflow = overflow_multiplier;
      end
      SELECT_DIVIDER: begin
        data_out = data_divider;
        overflow = overflow_divider;
      end
      default: begin
        data_out = data_adder;
        overflow = overflow_adder;
      end
    endcase
  end

endmodule

// File: hw/scalar_float_divider.sv
// Double-precision divider with a start and ready pulse
// The quotient comes back one clock after start
// Overflow also flags a divisor of zero magnitude

`timescale 1ns/100ps

module scalar_float_divider (
  // Global
  input  logic                                         CLK,
  input  logic                                         RST,

  // Control
  input  logic                                         start,
  output logic                                         ready,

  // Data
  input  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] data_a,
  input  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] data_b,
  output logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] data_out,
  output logic                                         overflow
);

  //////////////////////////////////////////////////////////////////////
  // States
  //////////////////////////////////////////////////////////////////////

  localparam logic STARTER_STATE = 1'b0;
  localparam logic ENDER_STATE   = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // FSM
  logic divider_state;

  // Dividend and divisor
  real data_a_int;
  real data_b_int;

  // Divisor was +0 or -0
  logic zero_divisor;

  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] operand_a_bits;
  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] operand_b_bits;
  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] quotient_bits;

  //////////////////////////////////////////////////////////////////////
  // Body
  //////////////////////////////////////////////////////////////////////

  assign operand_a_bits = $realtobits(data_a_int);
  assign operand_b_bits = $realtobits(data_b_int);

  // Zero divisor yields a signed infinity, 0/0 a NaN
  assign quotient_bits  = $realtobits(data_a_int / data_b_int);

  // Capture, sign bit ignored for the zero check
  always_ff @(posedge CLK) begin
    if (divider_state == STARTER_STATE && start) begin
      data_a_int   <= $bitstoreal(data_a);
      data_b_int   <= $bitstoreal(data_b);
      zero_divisor <= (data_b[accelerator_arithmetic_pkg::DATA_SIZE-2:0] == '0);
    end
  end

  // Control and result
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out      <= accelerator_arithmetic_pkg::ZERO_DATA;
      overflow      <= 1'b0;
      ready         <= 1'b0;
      divider_state <= STARTER_STATE;
    end else begin
      case (divider_state)
        STARTER_STATE: begin
          ready <= 1'b0;
          if (start) begin
            divider_state <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          data_out      <= quotient_bits;
          // Either rule raises the flag
          overflow      <= zero_divisor |
                           accelerator_arithmetic_pkg::float_overflow(operand_a_bits,
                                                                     operand_b_bits,
                                                                     quotient_bits);
          ready         <= 1'b1;
          divider_state <= STARTER_STATE;
        end
        default: begin
          divider_state <= STARTER_STATE;
        end
      endcase
    end
  end

endmodule

// File: hw/scalar_float_multiplier.sv
// Double-precision multiplier with a start and ready pulse
// The product and its overflow flag come back one clock after start

`timescale 1ns/100ps

module scalar_float_multiplier (
  // Global
  input  logic                                         CLK,
  input  logic                                         RST,

  // Control
  input  logic                                         start,
  output logic                                         ready,

  // Data
  input  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] data_a,
  input  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] data_b,
  output logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] data_out,
  output logic                                         overflow
);

  //////////////////////////////////////////////////////////////////////
  // States
  //////////////////////////////////////////////////////////////////////

  localparam logic STARTER_STATE = 1'b0;
  localparam logic ENDER_STATE   = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic multiplier_state;

  real data_a_int;
  real data_b_int;

  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] operand_a_bits;
  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] operand_b_bits;
  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] product_bits;

  //////////////////////////////////////////////////////////////////////
  // Body
  //////////////////////////////////////////////////////////////////////

  assign operand_a_bits = $realtobits(data_a_int);
  assign operand_b_bits = $realtobits(data_b_int);
  assign product_bits   = $realtobits(data_a_int * data_b_int);

  // Operands held while the product is formed
  always_ff @(posedge CLK) begin
    if (multiplier_state == STARTER_STATE && start) begin
      data_a_int <= $bitstoreal(data_a);
      data_b_int <= $bitstoreal(data_b);
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out         <= accelerator_arithmetic_pkg::ZERO_DATA;
      overflow         <= 1'b0;
      ready            <= 1'b0;
      multiplier_state <= STARTER_STATE;
    end else begin
      case (multiplier_state)
        STARTER_STATE: begin
          ready <= 1'b0;
          if (start) begin
            multiplier_state <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          // Large finite operands can round up to infinity
          data_out         <= product_bits;
          overflow         <= accelerator_arithmetic_pkg::float_overflow(operand_a_bits,
                                                                        operand_b_bits,
                                                                        product_bits);
          ready            <= 1'b1;
          multiplier_state <= STARTER_STATE;
        end
        default: begin
          multiplier_state <= STARTER_STATE;
        end
      endcase
    end
  end

endmodule

// File: hw/scalar_float_adder.sv
// Double-precision adder and subtractor with a start and ready pulse
// Operands are taken on start, the sum comes back one clock later
// Subtract negates the second operand when it is captured

`timescale 1ns/100ps

module scalar_float_adder (
  // Global
  input  logic                                         CLK,
  input  logic                                         RST,

  // Control
  input  logic                                         start,
  input  logic                                         subtract,
  output logic                                         ready,

  // Data
  input  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] data_a,
  input  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] data_b,
  output logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] data_out,
  output logic                                         overflow
);

  //////////////////////////////////////////////////////////////////////
  // States
  //////////////////////////////////////////////////////////////////////

  localparam logic STARTER_STATE = 1'b0;
  localparam logic ENDER_STATE   = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // FSM
  logic adder_state;

  // Captured operands as reals
  real data_a_int;
  real data_b_int;

  // Operands and sum back in bit form
  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] operand_a_bits;
  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] operand_b_bits;
  logic [accelerator_arithmetic_pkg::DATA_SIZE-1:0] sum_bits;

  //////////////////////////////////////////////////////////////////////
  // Body
  //////////////////////////////////////////////////////////////////////

  // Second operand already carries its sign for subtraction
  assign operand_a_bits = $realtobits(data_a_int);
  assign operand_b_bits = $realtobits(data_b_int);
  assign sum_bits       = $realtobits(data_a_int + data_b_int);

  // Operand capture, only in the starter state
  always_ff @(posedge CLK) begin
    if (adder_state == STARTER_STATE && start) begin
      data_a_int <= $bitstoreal(data_a);
      if (subtract) begin
        data_b_int <= -$bitstoreal(data_b);
      end else begin
        data_b_int <= $bitstoreal(data_b);
      end
    end
  end

  // Control and result
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out    <= accelerator_arithmetic_pkg::ZERO_DATA;
      overflow    <= 1'b0;
      ready       <= 1'b0;
      adder_state <= STARTER_STATE;
    end else begin
      case (adder_state)
        STARTER_STATE: begin
          // Ready lasts one cycle
          ready <= 1'b0;
          if (start) begin
            adder_state <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          data_out    <= sum_bits;
          overflow    <= accelerator_arithmetic_pkg::float_overflow(operand_a_bits,
                                                                   operand_b_bits,
                                                                   sum_bits);
          ready       <= 1'b1;
          adder_state <= STARTER_STATE;
        end
        default: begin
          adder_state <= STARTER_STATE;
        end
      endcase
    end
  end

endmodule

// File: hw/accelerator_arithmetic_pkg.sv
// Shared definitions for the scalar floating-point unit
// Data width, operation codes and the overflow rule used by every block
// Referenced by scoped names from the RTL and the testbench

package accelerator_arithmetic_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data
  //////////////////////////////////////////////////////////////////////

  // IEEE-754 double precision operands and results
  localparam int DATA_SIZE = 64;

  localparam logic [DATA_SIZE-1:0] ZERO_DATA = '0;

  // Exponent field of a double
  localparam int EXPONENT_MSB = 62;
  localparam int EXPONENT_LSB = 52;

  //////////////////////////////////////////////////////////////////////
  // Operations
  //////////////////////////////////////////////////////////////////////

  localparam int OPERATION_SIZE = 2;

  localparam logic [OPERATION_SIZE-1:0] OP_ADD = 2'd0;
  localparam logic [OPERATION_SIZE-1:0] OP_SUB = 2'd1;
  localparam logic [OPERATION_SIZE-1:0] OP_MUL = 2'd2;
  localparam logic [OPERATION_SIZE-1:0] OP_DIV = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // Overflow rule
  //////////////////////////////////////////////////////////////////////

  // Finite operands in, all-ones exponent out
  function automatic logic float_overflow(input logic [DATA_SIZE-1:0] operand_a,
                                          input logic [DATA_SIZE-1:0] operand_b,
                                          input logic [DATA_SIZE-1:0] result);
    logic finite_a;
    logic finite_b;
    finite_a = ~(&operand_a[EXPONENT_MSB:EXPONENT_LSB]);
    finite_b = ~(&operand_b[EXPONENT_MSB:EXPONENT_LSB]);
    return finite_a & finite_b & (&result[EXPONENT_MSB:EXPONENT_LSB]);
  endfunction

endpackage
